// ==== bench/l1d_input.txt ====
# name op address write_data expected_read_data expected_miss
# op R read, W write, F flush pulse, L peek into the L2 model
cold_read_miss       R 000010c4 00000000 5a5a10c4 1
cold_read_again      R 000010c4 00000000 5a5a10c4 0
write_hit            W 000010c8 deadbeef 00000000 0
read_written_word    R 000010c8 00000000 deadbeef 0
neighbor_below       R 000010c4 00000000 5a5a10c4 0
neighbor_above       R 000010cc 00000000 5a5a10cc 0
neighbor_last        R 000010fc 00000000 5a5a10fc 0
# set 5 with tags 1, 2 and 3
lru_fill_a           R 00000944 00000000 5a5a0944 1
lru_fill_b           R 00001148 00000000 5a5a1148 1
lru_touch_a          R 00000944 00000000 5a5a0944 0
lru_evict_b          R 0000194c 00000000 5a5a194c 1
lru_a_survives       R 00000940 00000000 5a5a0940 0
lru_b_misses         R 00001148 00000000 5a5a1148 1
lru_c_misses         R 0000194c 00000000 5a5a194c 1
# set 7 with tags 4, 5 and 6
wb_write_miss        W 000021c8 12345678 00000000 1
wb_fill_way1         R 000029c0 00000000 5a5a29c0 1
wb_l2_before         L 000021c8 00000000 5a5a21c8 0
wb_evict_dirty       R 000031c0 00000000 5a5a31c0 1
wb_l2_word           L 000021c8 00000000 12345678 0
wb_l2_neighbor       L 000021c4 00000000 5a5a21c4 0
wb_reread            R 000021c8 00000000 12345678 1
wb_reread_neighbor   R 000021cc 00000000 5a5a21cc 0
# dirty words dropped by flush
flush_write_hit      W 000021c8 cafef00d 00000000 0
flush_read_hit       R 000021c8 00000000 cafef00d 0
flush_pulse          F 00000000 00000000 00000000 0
flush_read_miss      R 000021c8 00000000 12345678 1
flush_lost_dirty     R 000010c8 00000000 5a5a10c8 1
flush_l2_kept        L 000021c8 00000000 12345678 0
flush_refill_hit     R 000021c8 00000000 12345678 0

// ==== bench/l1d_props.sv ====
`timescale 1ns/1ps

module l1d_props
(
    input logic clk,
    input logic nrst,
    input logic l2_read,
    input logic l2_write,
    input logic l2_ready,
    input logic refill,
    input logic l1d_miss
);

    int fail_count = 0;

    // one L2 transfer at a time
    no_read_write: assert property (@(posedge clk) disable iff (!nrst)
        !(l2_read && l2_write))
        else
        begin
            $error("l2 read and l2 write high in the same cycle");
            fail_count++;
        end

    read_held: assert property (@(posedge clk) disable iff (!nrst)
        l2_read && !l2_ready |=> l2_read)
        else
        begin
            $error("l2 read dropped before l2_ready");
            fail_count++;
        end

    write_held: assert property (@(posedge clk) disable iff (!nrst)
        l2_write && !l2_ready |=> l2_write)
        else
        begin
            $error("l2 write dropped before l2_ready");
            fail_count++;
        end

    // fill data lands one cycle after the allocate ready
    refill_after_ready: assert property (@(posedge clk) disable iff (!nrst)
        l2_read && l2_ready |=> refill)
        else
        begin
            $error("no refill strobe after allocate ready");
            fail_count++;
        end

    miss_single: assert property (@(posedge clk) disable iff (!nrst)
        l1d_miss |=> !l1d_miss)
        else
        begin
            $error("l1d_miss high for two cycles");
            fail_count++;
        end

endmodule

bind l1d_controller l1d_props props0
(
    .clk      (clk),
    .nrst     (nrst),
    .l2_read  (l2_read),
    .l2_write (l2_write),
    .l2_ready (l2_ready),
    .refill   (refill),
    .l1d_miss (l1d_miss)
);

// ==== bench/l1d_tb.sv ====
`timescale 1ns/1ps

module l1d_tb;

    localparam int timeout_cycles = 200;

    logic                             clk;
    logic                             nrst;
    cache_bus_pkg::cpu_req_t          cpu_req;
    logic                             flush;
    logic                             stall;
    logic [31:0]                      rdata;
    logic                             l1d_miss;
    cache_bus_pkg::l2_req_t           l2_req;
    logic                             l2_ready;
    logic [cache_cfg_pkg::line_w-1:0] l2_rdata;

    // lines written back by the cache
    logic [cache_cfg_pkg::line_w-1:0] l2_mem [logic [cache_cfg_pkg::line_addr_w-1:0]];
    logic [31:0] lfsr;
    int          l2_wait;   // cycles left before ready
    int          tests;
    int          fails;

    l1d_cache dut0
    (
        .clk      (clk),
        .nrst     (nrst),
        .cpu_req  (cpu_req),
        .flush    (flush),
        .stall    (stall),
        .rdata    (rdata),
        .l1d_miss (l1d_miss),
        .l2_req   (l2_req),
        .l2_ready (l2_ready),
        .l2_rdata (l2_rdata)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    // untouched lines hold their own byte addresses
    function automatic logic [cache_cfg_pkg::line_w-1:0] l2_line_of(
        input logic [cache_cfg_pkg::line_addr_w-1:0] line_addr);
        logic [cache_cfg_pkg::line_w-1:0] line;
        if (l2_mem.exists(line_addr))
            return l2_mem[line_addr];
        for (int w = 0; w < cache_cfg_pkg::line_words; w++)
            line[w*32 +: 32] = {line_addr, w[3:0], 2'b00} ^ 32'h5a5a0000;
        return line;
    endfunction

    task automatic pick_l2_delay(output int delay);
        logic [1:0] bits;
        bits = '0;
        for (int i = 0; i < 2; i++)
        begin
            bits = {bits[0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        delay = 1 + bits;   // 1 to 4 cycles
    endtask

    // one clock of the L2 model, right after a rising edge
    task automatic serve_l2();
        l2_ready <= 1'b0;
        if (l2_wait > 0)
        begin
            l2_wait = l2_wait - 1;
            if (l2_wait == 0)
            begin
                if (l2_req.write)
                    l2_mem[l2_req.addr] = l2_req.wdata;
                else
                    l2_rdata <= l2_line_of(l2_req.addr);
                l2_ready <= 1'b1;
            end
        end
        else if ((l2_req.read || l2_req.write) && !l2_ready)   // skip the level after ready
            pick_l2_delay(l2_wait);
    endtask

    task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] got,
                              output logic got_miss, output logic timed_out);
        int   cycles;
        logic seen_stall;
        logic finished;
        cycles     = 0;
        seen_stall = 1'b0;
        finished   = 1'b0;
        got        = '0;
        got_miss   = 1'b0;
        @(posedge clk);
        cpu_req <= '{read: (op == "R"), write: (op == "W"), addr: addr, wdata: wdata};
        while (!finished && cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
            serve_l2();
            if (l1d_miss)
                got_miss = 1'b1;
            if (stall)
                seen_stall = 1'b1;
            else if (seen_stall)
            begin
                got      = rdata;    // completion cycle
                finished = 1'b1;
                cpu_req <= '0;
            end
        end
        if (!finished)
            cpu_req <= '0;
        timed_out = !finished;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic run_test(input logic [8*24-1:0] name, input logic [7:0] op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_data, input int exp_miss,
                            output logic stop);
        logic [cache_cfg_pkg::line_w-1:0] line;
        logic [31:0] got;
        logic        got_miss;
        logic        timed_out;
        tests++;
        stop      = 1'b0;
        timed_out = 1'b0;
        got       = '0;
        got_miss  = 1'b0;
        if (op == "F")
            pulse_flush();
        else if (op == "L")
        begin
            line = l2_line_of(addr[31:6]);   // peek into the L2 model
            got  = line[addr[5:2]*32 +: 32];
        end
        else
            run_access(op, addr, wdata, got, got_miss, timed_out);
        if (timed_out)
        begin
            $display("timeout in %0s: access not finished within %0d cycles",
                     name, timeout_cycles);
            fails++;
            stop = 1'b1;
        end
        else if ((op == "R" || op == "L") && got !== exp_data)
        begin
            $display("[FAIL] %0s: expected data %h, actual %h", name, exp_data, got);
            fails++;
        end
        else if ((op == "R" || op == "W") && got_miss !== exp_miss[0])
        begin
            $display("[FAIL] %0s: expected miss %0d, actual %0d", name, exp_miss, got_miss);
            fails++;
        end
        else
            $display("[PASS] %0s", name);
    endtask

    initial
    begin
        int              fd;
        int              n;
        int              exp_miss;
        logic [8*24-1:0] name;
        logic [8*128-1:0] skip;
        logic [7:0]      op;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        logic [31:0]     exp_data;
        logic            at_end;
        clk      = 1'b0;
        nrst     = 1'b0;
        cpu_req  = '0;
        flush    = 1'b0;
        l2_ready = 1'b0;
        l2_rdata = '0;
        lfsr     = 32'hb4ba;
        l2_wait  = 0;
        tests    = 0;
        fails    = 0;
        at_end   = 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;

        fd = $fopen("bench/l1d_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open bench/l1d_input.txt");
            fails++;
            at_end = 1'b1;
        end
        while (!at_end)
        begin
            n = $fscanf(fd, "%s", name);
            if (n != 1)
                at_end = 1'b1;
            else if (name == "#")
                n = $fgets(skip, fd);
            else
            begin
                n = $fscanf(fd, "%s %h %h %h %d", op, addr, wdata, exp_data, exp_miss);
                if (n != 5)
                begin
                    $display("malformed line in the input file at %0s", name);
                    fails++;
                    at_end = 1'b1;
                end
                else
                    run_test(name, op, addr, wdata, exp_data, exp_miss, at_end);
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 tests, tests - fails, fails, dut0.ctrl0.props0.fail_count);
        if (fails == 0 && tests > 0 && dut0.ctrl0.props0.fail_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

    // cpu side access, one whole word
    typedef struct packed
    {
        logic                             read;
        logic                             write;
        logic [cache_cfg_pkg::addr_w-1:0] addr;
        logic [cache_cfg_pkg::word_w-1:0] wdata;
    } cpu_req_t;

    // byte address broken into its cache fields
    typedef struct packed
    {
        logic [cache_cfg_pkg::tag_w-1:0]      tag;
        logic [cache_cfg_pkg::index_w-1:0]    index;
        logic [cache_cfg_pkg::word_sel_w-1:0] word;
        logic [cache_cfg_pkg::byte_sel_w-1:0] byte_off;  // always ignored
    } cpu_addr_t;

    // request towards L2, full line transfers only
    typedef struct packed
    {
        logic                                  read;
        logic                                  write;
        logic [cache_cfg_pkg::line_addr_w-1:0] addr;   // tag and index
        logic [cache_cfg_pkg::line_w-1:0]      wdata;  // victim line on write back
    } l2_req_t;

endpackage

// ==== hw/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // address split is tag | index | word | byte
    localparam int addr_w      = 32;
    localparam int word_w      = 32;
    localparam int byte_sel_w  = 2;
    localparam int word_sel_w  = 4;
    localparam int index_w     = 5;
    localparam int tag_w       = addr_w - index_w - word_sel_w - byte_sel_w;  // 21

    localparam int sets        = 32;
    localparam int ways        = 2;
    localparam int lines       = sets * ways;
    localparam int line_sel_w  = index_w + 1;           // set index plus way bit
    localparam int line_words  = 16;
    localparam int line_w      = line_words * word_w;   // 512
    localparam int line_addr_w = tag_w + index_w;       // 26

    typedef enum logic [1:0]
    {
        s_idle       = 2'b00,
        s_compare    = 2'b01,
        s_write_back = 2'b10,
        s_allocate   = 2'b11
    } ctrl_state_e;

endpackage

// ==== hw/l1d_cache.sv ====
`timescale 1ns/1ps

module l1d_cache
(
    input  logic                              clk,
    input  logic                              nrst,
    input  cache_bus_pkg::cpu_req_t           cpu_req,
    input  logic                              flush,
    output logic                              stall,
    output logic [cache_cfg_pkg::word_w-1:0]  rdata,
    output logic                              l1d_miss,
    output cache_bus_pkg::l2_req_t            l2_req,
    input  logic                              l2_ready,
    input  logic [cache_cfg_pkg::line_w-1:0]  l2_rdata
);

    cache_bus_pkg::cpu_addr_t addr_fields;

    logic                                  refill;
    logic                                  update;
    logic                                  way;
    logic                                  l2_read;
    logic                                  l2_write;
    logic [cache_cfg_pkg::line_addr_w-1:0] l2_addr;
    logic [cache_cfg_pkg::line_w-1:0]      victim_line;

    assign addr_fields = cpu_req.addr;

    l1d_controller ctrl0
    (
        .clk      (clk),
        .nrst     (nrst),
        .cpu_req  (cpu_req),
        .flush    (flush),
        .l2_ready (l2_ready),
        .stall    (stall),
        .refill   (refill),
        .update   (update),
        .way      (way),
        .l1d_miss (l1d_miss),
        .l2_read  (l2_read),
        .l2_write (l2_write),
        .l2_addr  (l2_addr)
    );

    l1d_data_array data0
    (
        .clk       (clk),
        .index     (addr_fields.index),
        .way       (way),
        .word_sel  (addr_fields.word),
        .refill    (refill),
        .fill_line (l2_rdata),
        .update    (update),
        .wdata     (cpu_req.wdata),
        .line_out  (victim_line),
        .word_out  (rdata)
    );

    // victim data only matters while write is high
    assign l2_req = '{read: l2_read, write: l2_write, addr: l2_addr, wdata: victim_line};

endmodule

// ==== hw/l1d_controller.sv ====
`timescale 1ns/1ps

module l1d_controller
(
    input  logic                                  clk,
    input  logic                                  nrst,
    input  cache_bus_pkg::cpu_req_t               cpu_req,
    input  logic                                  flush,
    input  logic                                  l2_ready,
    output logic                                  stall,
    output logic                                  refill,
    output logic                                  update,
    output logic                                  way,
    output logic                                  l1d_miss,
    output logic                                  l2_read,
    output logic                                  l2_write,
    output logic [cache_cfg_pkg::line_addr_w-1:0] l2_addr
);

    cache_cfg_pkg::ctrl_state_e state_q;
    cache_cfg_pkg::ctrl_state_e state_d;
    cache_bus_pkg::cpu_addr_t   req_addr;

    logic [cache_cfg_pkg::tag_w-1:0] tag_mem [cache_cfg_pkg::lines];
    logic [cache_cfg_pkg::lines-1:0] valid_q;
    logic [cache_cfg_pkg::lines-1:0] dirty_q;
    logic [cache_cfg_pkg::sets-1:0]  lru_q;      // way to replace next, per set

    logic hit_q;
    logic miss_q;
    logic check_q;      // set once a refill happened, keeps the way
    logic done_q;       // completion cycle, request still held by the cpu
    logic way_q;
    logic refill_q;
    logic update_q;
    logic l2_read_q;
    logic l2_write_q;

    logic [cache_cfg_pkg::line_sel_w-1:0] sel0;
    logic [cache_cfg_pkg::line_sel_w-1:0] sel1;
    logic [cache_cfg_pkg::line_sel_w-1:0] victim_sel;
    logic match0;
    logic match1;
    logic any_match;
    logic req_valid;
    logic fresh_compare;
    logic alloc_done;

    assign req_addr   = cpu_req.addr;
    assign req_valid  = cpu_req.read | cpu_req.write;
    assign sel0       = {req_addr.index, 1'b0};
    assign sel1       = {req_addr.index, 1'b1};
    assign victim_sel = {req_addr.index, way_q};

    assign match0    = valid_q[sel0] && (tag_mem[sel0] == req_addr.tag);
    assign match1    = valid_q[sel1] && (tag_mem[sel1] == req_addr.tag);
    assign any_match = match0 | match1;

    // first compare cycle, result not registered yet
    assign fresh_compare = (state_q == cache_cfg_pkg::s_compare) && !hit_q && !miss_q;
    assign alloc_done    = (state_q == cache_cfg_pkg::s_allocate) && l2_ready;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state_q <= cache_cfg_pkg::s_idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            cache_cfg_pkg::s_idle:
                if (req_valid && !done_q)
                    state_d = cache_cfg_pkg::s_compare;
            cache_cfg_pkg::s_compare:
                if (hit_q)
                    state_d = cache_cfg_pkg::s_idle;
                else if (miss_q && dirty_q[victim_sel])
                    state_d = cache_cfg_pkg::s_write_back;  // any miss with a dirty victim
                else if (miss_q)
                    state_d = cache_cfg_pkg::s_allocate;
            cache_cfg_pkg::s_write_back:
                if (l2_ready)
                    state_d = cache_cfg_pkg::s_allocate;
            cache_cfg_pkg::s_allocate:
                if (l2_ready)
                    state_d = cache_cfg_pkg::s_compare;
            default:
                state_d = cache_cfg_pkg::s_idle;
        endcase
    end

    // registered tag match
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            hit_q  <= fresh_compare && any_match;
            miss_q <= fresh_compare && !any_match;
            done_q <= (state_q == cache_cfg_pkg::s_compare) && hit_q;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            check_q <= 1'b0;
        else if (state_q == cache_cfg_pkg::s_allocate)
            check_q <= 1'b1;
        else if (state_q == cache_cfg_pkg::s_idle)
            check_q <= 1'b0;
    end

    // hit way first, then an empty way, then the lru one
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            way_q <= 1'b0;
        else if (fresh_compare && !check_q)
        begin
            if (match0)
                way_q <= 1'b0;
            else if (match1)
                way_q <= 1'b1;
            else if (!valid_q[sel0])
                way_q <= 1'b0;
            else if (!valid_q[sel1])
                way_q <= 1'b1;
            else
                way_q <= lru_q[req_addr.index];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru_q <= '0;
        else if ((state_q == cache_cfg_pkg::s_compare) && hit_q)
            lru_q[req_addr.index] <= ~way_q;  // other way goes next
    end

    // flush drops dirty lines as well
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if ((state_q == cache_cfg_pkg::s_idle) && flush)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (alloc_done)
        begin
            valid_q[victim_sel] <= 1'b1;
            dirty_q[victim_sel] <= 1'b0;
        end
        else if ((state_q == cache_cfg_pkg::s_compare) && hit_q && cpu_req.write)
            dirty_q[victim_sel] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (alloc_done)
            tag_mem[victim_sel] <= req_addr.tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            refill_q   <= 1'b0;
            update_q   <= 1'b0;
            l2_read_q  <= 1'b0;
            l2_write_q <= 1'b0;
        end
        else
        begin
            refill_q   <= alloc_done;
            update_q   <= (state_q == cache_cfg_pkg::s_compare) && hit_q && cpu_req.write;
            l2_read_q  <= (state_d == cache_cfg_pkg::s_allocate);   // high for the whole state
            l2_write_q <= (state_d == cache_cfg_pkg::s_write_back);
        end
    end

    // victim line address while writing back, else the requested line
    assign l2_addr = (state_q == cache_cfg_pkg::s_write_back) ?
                     {tag_mem[victim_sel], req_addr.index} :
                     {req_addr.tag, req_addr.index};

    assign stall    = (state_q != cache_cfg_pkg::s_idle);
    assign refill   = refill_q;
    assign update   = update_q;
    assign way      = way_q;
    assign l1d_miss = miss_q;
    assign l2_read  = l2_read_q;
    assign l2_write = l2_write_q;

endmodule

// ==== hw/l1d_data_array.sv ====
`timescale 1ns/1ps

module l1d_data_array
(
    input  logic                                 clk,
    input  logic [cache_cfg_pkg::index_w-1:0]    index,
    input  logic                                 way,
    input  logic [cache_cfg_pkg::word_sel_w-1:0] word_sel,
    input  logic                                 refill,
    input  logic [cache_cfg_pkg::line_w-1:0]     fill_line,
    input  logic                                 update,
    input  logic [cache_cfg_pkg::word_w-1:0]     wdata,
    output logic [cache_cfg_pkg::line_w-1:0]     line_out,
    output logic [cache_cfg_pkg::word_w-1:0]     word_out
);

    // one entry per line, words packed low to high
    logic [cache_cfg_pkg::line_words-1:0][cache_cfg_pkg::word_w-1:0]
        mem [cache_cfg_pkg::lines];

    logic [cache_cfg_pkg::line_sel_w-1:0] sel;

    assign sel = {index, way};  // same line numbering as the tag array

    // refill and update never come in the same cycle
    always_ff @(posedge clk)
    begin
        if (refill)
            mem[sel] <= fill_line;
        else if (update)
            mem[sel][word_sel] <= wdata;  // single word of a write hit
    end

    // victim line towards L2
    assign line_out = mem[sel];

    // read data back to the cpu
    assign word_out = mem[sel][word_sel];

endmodule

// ==== list.f ====
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/l1d_controller.sv
hw/l1d_data_array.sv
hw/l1d_cache.sv
bench/l1d_props.sv
bench/l1d_tb.sv
